// File: bench/operandCheck_assert.sv
`default_nettype none

module operandCheck (
	input wire logic                  clk,
	input wire logic                  arstN,
	input wire logic                  inValid,
	input wire logic                  inReady,
	input wire operandPkg::opRequestT inReq,
	input wire logic                  outValid,
	input wire logic                  outReady,
	input wire operandPkg::opResultT  outResult
);

	timeunit 1ns;
	timeprecision 1ps;

	operandPkg::opResultT expQ [$];	// Expected results in acceptance order
	operandPkg::opResultT chkExp;
	operandPkg::opResultT chkGot;
	logic       chkValid;
	logic [2:0] latPipe;	// Requests accepted into an empty path
	int         pending;
	int         failCount = 0;

	function automatic operandPkg::opResultT refModel(operandPkg::opRequestT r);
		logic [31:0] w;
		logic [31:0] op;
		logic        c;
		int          n;
		w  = r.instr.raw;
		op = r.rmValue;
		c  = r.carryIn;
		n  = 0;
		case (w[27:25])
			3'b001:
			begin
				op = {24'd0, w[7:0]};
				for (int i = 0; i < 2 * int'(w[11:8]); i++)
					op = {op[0], op[31:1]};
				c = (w[11:8] != 4'd0) ? op[31] : c;
			end
			3'b000:
			begin
				if (w[4] && w[7])
					op = {24'd0, w[11:8], w[3:0]};	// Split offset of mode 3
				else if (!w[4] && w[6:5] == 2'b11 && w[11:7] == 5'd0)
				begin
					c  = op[0];
					op = {r.carryIn, op[31:1]};	// RRX
				end
				else if (!w[4])
				begin
					n = (w[11:7] == 5'd0 && w[6:5] != 2'b00) ? 32 : int'(w[11:7]);
					for (int i = 0; i < n; i++)
					begin
						c = (w[6:5] == 2'b00) ? op[31] : op[0];	// Bit about to leave
						case (w[6:5])
							2'b00:   op = {op[30:0], 1'b0};
							2'b01:   op = {1'b0, op[31:1]};
							2'b10:   op = {op[31], op[31:1]};
							default: op = {op[0], op[31:1]};
						endcase
					end
				end
			end
			3'b010: op = {20'd0, w[11:0]};
			3'b100:
			begin
				for (int i = 0; i < 16; i++)
					n = n + int'(w[i]);
				op = 32'(4 * n);
			end
			3'b101: op = 32'($signed(w[23:0]) * 4);	// Word offset in bytes
			default: ;
		endcase
		return {op, c};
	endfunction

	always @(posedge clk or negedge arstN)
	begin
		if (!arstN)
		begin
			expQ.delete();
			pending  <= 0;
			chkValid <= 1'b0;
			latPipe  <= '0;
		end
		else
		begin
			chkValid <= outValid && outReady;
			latPipe  <= {latPipe[1:0], inValid && inReady && pending == 0};
			pending  <= pending + int'(inValid && inReady) - int'(outValid && outReady);
			if (outValid && outReady)
				chkGot <= outResult;
			if (outValid && outReady && expQ.size() != 0)
				chkExp <= expQ.pop_front();	// Older entries leave before new ones join
			if (inValid && inReady)
				expQ.push_back(refModel(inReq));
		end
	end

	resetIdle: assert property (@(posedge clk) !arstN |-> !outValid && inReady)
		else
		begin
			$error("outputs active during reset");
			failCount++;
		end

	resultMatch: assert property (@(posedge clk) disable iff (!arstN)
		chkValid |-> chkGot == chkExp)
		else
		begin
			$error("result differs from reference model");
			failCount++;
		end

	noExtraResult: assert property (@(posedge clk) disable iff (!arstN)
		outValid |-> pending > 0)
		else
		begin
			$error("result without an outstanding request");
			failCount++;
		end

	holdResult: assert property (@(posedge clk) disable iff (!arstN)
		outValid && !outReady |=> outValid && $stable(outResult))
		else
		begin
			$error("result dropped or changed while stalled");
			failCount++;
		end

	emptyLatency: assert property (@(posedge clk) disable iff (!arstN)
		latPipe[2] |-> outValid)
		else
		begin
			$error("empty path did not deliver after three cycles");
			failCount++;
		end

endmodule

bind operandPath operandCheck i_operandCheck (.*);

`default_nettype wire

// File: bench/operandPathTb.sv
`default_nettype none

module operandPathTb;

	timeunit 1ns;
	timeprecision 1ps;

	logic                  clk = 1'b0;
	logic                  arstN;
	logic                  inValid;
	logic                  inReady;
	operandPkg::opRequestT inReq;
	logic                  outValid;
	logic                  outReady;
	operandPkg::opResultT  outResult;

	logic  tookReq = 1'b0;	// Handshake seen at the last rising edge
	int    cycles;
	int    resCount;
	int    sentCount;
	int    cmpErrors;
	int    cmpBase;
	int    procErrors;
	int    failBase;
	int    testsRun;
	int    testsFailed;
	bit    randomReady;
	string testName;
	operandPkg::opRequestT reqs [$];
	int    cycleLimit = 40 * 73 + 5;	// 73 requests in all tests plus reset

	operandPath i_operandPath (.*);

	initial
	begin
		forever #10 clk = ~clk;
	end

	always @(posedge clk)
	begin
		cycles  <= cycles + 1;
		tookReq <= inValid && inReady;
		if (outValid && outReady)
			resCount <= resCount + 1;
		if (i_operandPath.i_operandCheck.chkValid
			&& i_operandPath.i_operandCheck.chkGot != i_operandPath.i_operandCheck.chkExp)
		begin
			$display("mismatch in %s: expected %h carry %b, actual %h carry %b", testName,
				i_operandPath.i_operandCheck.chkExp.operand,
				i_operandPath.i_operandCheck.chkExp.carryOut,
				i_operandPath.i_operandCheck.chkGot.operand,
				i_operandPath.i_operandCheck.chkGot.carryOut);
			cmpErrors <= cmpErrors + 1;
		end
	end

	always @(posedge clk)
	begin
		if (cycles >= cycleLimit)
		begin
			$display("Timeout: simulation stopped after %0d cycles", cycles);
			$display("Some tests failed");
			$finish;
		end
	end

	function automatic operandPkg::opRequestT makeReq(logic [31:0] word, logic [31:0] rm,
		logic cin);
		operandPkg::opRequestT r;
		r.instr.raw = word;
		r.rmValue   = rm;
		r.carryIn   = cin;
		return r;
	endfunction

	task automatic stepCycle();
		@(negedge clk);
		if (randomReady)
			outReady = 1'($urandom % 2);
	endtask

	task automatic sendList();
		foreach (reqs[i])
		begin
			inValid = 1'b1;
			inReq   = reqs[i];
			do
				stepCycle();
			while (!tookReq);
			sentCount++;
		end
		inValid = 1'b0;
		reqs.delete();
	endtask

	task automatic beginTest(input string name);
		testName   = name;
		procErrors = 0;
		cmpBase    = cmpErrors;
		failBase   = i_operandPath.i_operandCheck.failCount;
	endtask

	task automatic endTest();
		int errs;
		while (resCount < sentCount)
			stepCycle();
		repeat (3) stepCycle();	// Checker sees the last result a cycle late
		if (resCount != sentCount)
		begin
			$display("mismatch in %s: expected %0d results, actual %0d", testName, sentCount,
				resCount);
			procErrors++;
		end
		errs = procErrors + (cmpErrors - cmpBase)
			+ (i_operandPath.i_operandCheck.failCount - failBase);
		testsRun++;
		if (errs != 0)
			testsFailed++;
		$display("%s: %s, %0d errors", testName, (errs == 0) ? "ok" : "FAILED", errs);
		randomReady = 1'b0;
		outReady    = 1'b1;
	endtask

	task automatic checkIdle();
		if (outValid || !inReady)
		begin
			$display("%s: DUT is not idle around reset", testName);
			procErrors++;
		end
	endtask

	task automatic rotatedImmediates();
		beginTest("rotImm");
		for (int r = 0; r < 16; r++)
			reqs.push_back(makeReq({4'hE, 3'b001, 13'h0, 4'(r), 8'($urandom)}, $urandom,
				1'((r + 1) % 2)));	// Carry-in set where rotate is zero
		sendList();
		endTest();
	endtask

	task automatic immediateShifts();
		logic [4:0] amt;
		beginTest("shiftImm");
		for (int t = 0; t < 4; t++)
		begin
			for (int k = 0; k < 4; k++)
			begin
				amt = (k == 0) ? 5'd0 : (k == 3) ? 5'd31 : 5'($urandom_range(1, 30));
				reqs.push_back(makeReq({4'hE, 3'b000, 13'h0, amt, 2'(t), 1'b0, 4'h0},
					$urandom, 1'($urandom % 2)));
			end
		end
		sendList();
		endTest();
	endtask

	task automatic offsetForms();
		logic [2:0] passCls [4];
		beginTest("offsets");
		passCls     = '{3'b000, 3'b011, 3'b110, 3'b111};	// Register shift and unlisted classes
		randomReady = 1'b1;
		for (int k = 0; k < 4; k++)
		begin
			reqs.push_back(makeReq({4'hE, 3'b010, 13'h0, 12'($urandom)}, $urandom, 1'b1));
			reqs.push_back(makeReq({4'hE, 3'b000, 13'h0, 4'($urandom), 4'b1011, 4'($urandom)},
				$urandom, 1'b0));
			reqs.push_back(makeReq({4'hE, 3'b101, 1'($urandom % 2), 24'($urandom)}, $urandom,
				1'b1));
			reqs.push_back(makeReq({4'hE, passCls[k], 13'h0, 4'($urandom), 1'b0, 2'($urandom),
				1'b1, 4'($urandom)}, $urandom, 1'($urandom % 2)));
		end
		for (int k = 0; k < 6; k++)
			reqs.push_back(makeReq({4'hE, 3'b100, 5'b01001, 4'h0,
				(k == 0) ? 16'hFFFF : 16'($urandom)}, $urandom, 1'b0));
		sendList();
		endTest();
	endtask

	task automatic backPressure();
		int accepted;
		beginTest("backPressure");
		for (int k = 0; k < 8; k++)
			reqs.push_back(makeReq({4'hE, 3'b111, 25'h0}, 32'h1000_0000 + 32'(k), 1'(k % 2)));
		outReady = 1'b0;
		accepted = 0;
		inValid  = 1'b1;
		inReq    = reqs[0];
		for (int c = 0; accepted < 8; c++)
		begin
			if (c == 12)
			begin
				if (accepted != 6)
				begin
					$display("mismatch in %s: expected 6 accepted, actual %0d", testName,
						accepted);
					procErrors++;
				end
				if (inReady)
				begin
					$display("%s: inReady is still high with the path full", testName);
					procErrors++;
				end
				outReady = 1'b1;	// Release the stall
			end
			stepCycle();
			if (tookReq)
			begin
				accepted++;
				sentCount++;
				if (accepted < 8)
					inReq = reqs[accepted];
				else
					inValid = 1'b0;
			end
		end
		reqs.delete();
		endTest();
	endtask

	task automatic latencyAndThroughput();
		int lat;
		int start;
		beginTest("latency");
		reqs.push_back(makeReq({4'hE, 3'b010, 13'h0, 12'h123}, 32'h0, 1'b0));
		sendList();
		lat = 0;
		while (!outValid)
		begin
			stepCycle();
			lat++;
		end
		if (lat != 2)
		begin
			$display("mismatch in %s: expected valid 2 edges after accept, actual %0d",
				testName, lat);
			procErrors++;
		end
		while (resCount < sentCount)
			stepCycle();
		for (int k = 0; k < 10; k++)
			reqs.push_back(makeReq({4'hE, 3'b000, 13'h0, 5'(k + 1), 2'(k), 1'b0, 4'h0},
				$urandom, 1'b1));
		start = cycles;
		sendList();
		while (resCount < sentCount)
			stepCycle();
		if (cycles - start != 13)	// Ten transfers plus three cycles of latency
		begin
			$display("mismatch in %s: expected 13 cycles for 10 results, actual %0d",
				testName, cycles - start);
			procErrors++;
		end
		endTest();
	endtask

	initial
	begin
		void'($urandom(78));
		arstN       = 1'b0;
		inValid     = 1'b0;
		inReq       = '0;
		outReady    = 1'b1;
		randomReady = 1'b0;
		beginTest("reset");
		repeat (5)
		begin
			@(negedge clk);
			checkIdle();
		end
		arstN = 1'b1;
		@(negedge clk);
		checkIdle();
		endTest();
		rotatedImmediates();
		immediateShifts();
		offsetForms();
		backPressure();
		latencyAndThroughput();
		$display("%0d tests run, %0d failed", testsRun, testsFailed);
		if (testsFailed == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: design/armIsaPkg.sv
`default_nettype none

package armIsaPkg;

	// Bits 27..25 of the instruction word
	typedef enum logic [2:0] {
		dataProcReg = 3'b000,	// Data processing, register operand
		dataProcImm = 3'b001,	// Data processing, rotated immediate
		memImm      = 3'b010,	// Load/store, 12-bit offset
		memReg      = 3'b011,	// Load/store, register offset
		memMulti    = 3'b100,	// Load/store multiple
		branch      = 3'b101,	// B and BL
		coprocMem   = 3'b110,
		coprocSwi   = 3'b111
	} instrClassT;

	typedef enum logic [1:0] {
		lsl = 2'b00,	// Logical shift left
		lsr = 2'b01,	// Logical shift right
		asr = 2'b10,	// Arithmetic shift right
		ror = 2'b11	// Rotate right, RRX when amount is zero
	} shiftTypeT;

	typedef struct packed {
		logic [3:0]  cond;
		instrClassT  instrClass;
		logic [3:0]  opcode;
		logic        setFlags;
		logic [3:0]  rn;
		logic [3:0]  rd;
		logic [11:0] operand2;
	} dataProcView;

	typedef struct packed {
		logic [3:0]  cond;
		instrClassT  instrClass;
		logic [4:0]  puswl;
		logic [3:0]  rn;
		logic [15:0] regList;
	} memMultiView;

	// One word, read either as operand2 or as a register list
	typedef union packed {
		dataProcView dp;
		memMultiView mm;
		logic [31:0] raw;
	} instrWordU;

	// Field positions inside operand2
	localparam int OP2_ROT_HI       = 11;	// Rotate, also high nibble of split offset
	localparam int OP2_ROT_LO       = 8;
	localparam int OP2_IMM8_HI      = 7;
	localparam int OP2_IMM8_LO      = 0;
	localparam int OP2_SHAMT_HI     = 11;
	localparam int OP2_SHAMT_LO     = 7;
	localparam int OP2_STYPE_HI     = 6;
	localparam int OP2_STYPE_LO     = 5;
	localparam int OP2_REGSHIFT_BIT = 4;	// Set for register shift and mode 3
	localparam int OP2_MODE3_BIT    = 7;	// Set together with bit 4 for mode 3
	localparam int OP2_RM_HI        = 3;	// Rm index, also low nibble of split offset
	localparam int OP2_RM_LO        = 0;

endpackage

`default_nettype wire

// File: design/instrIssue.sv
`default_nettype none

module instrIssue (
	input  wire logic                 clk,
	input  wire logic                 arstN,
	input  wire logic                 inValid,
	output logic                      inReady,
	input  wire operandPkg::opRequestT inReq,
	output logic                      issueValid,
	input  wire logic                 issueReady,
	output operandPkg::opEntryT       issueEntry
);

	operandPkg::operandFormT form;
	logic [11:0] op2;

	assign op2     = inReq.instr.dp.operand2;
	assign inReady = !issueValid || issueReady;	// Empty or draining this cycle

	always_comb
	begin
		case (inReq.instr.dp.instrClass)
			armIsaPkg::dataProcReg:
			begin
				if (!op2[armIsaPkg::OP2_REGSHIFT_BIT])
					form = operandPkg::shiftImm;
				else if (op2[armIsaPkg::OP2_MODE3_BIT])
					form = operandPkg::splitOffset;	// Halfword and signed byte transfers
				else
					form = operandPkg::passThrough;	// Register-specified shift
			end
			armIsaPkg::dataProcImm: form = operandPkg::rotImm;
			armIsaPkg::memImm:      form = operandPkg::offset12;
			armIsaPkg::memMulti:    form = operandPkg::multiCount;
			armIsaPkg::branch:      form = operandPkg::branchOffset;
			default:                form = operandPkg::passThrough;
		endcase
	end

	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
			issueValid <= 1'b0;
		else if (inReady)
			issueValid <= inValid;
	end

	always_ff @(posedge clk)
	begin
		if (inValid && inReady)
		begin
			issueEntry.form <= form;
			issueEntry.req  <= inReq;
		end
	end

endmodule

`default_nettype wire

// File: design/operandFifo.sv
`default_nettype none

module operandFifo (
	input  wire logic                clk,
	input  wire logic                arstN,
	input  wire logic                issueValid,
	output logic                     issueReady,
	input  wire operandPkg::opEntryT issueEntry,
	output logic                     bufValid,
	input  wire logic                bufReady,
	output operandPkg::opEntryT      bufEntry
);

	operandPkg::opEntryT mem [operandPkg::FIFO_DEPTH];

	logic [operandPkg::FIFO_PTR_W-1:0] wrPtr;
	logic [operandPkg::FIFO_PTR_W-1:0] rdPtr;
	logic [operandPkg::FIFO_CNT_W-1:0] count;
	logic full;
	logic wrEn;
	logic rdEn;

	assign full       = (count == operandPkg::FIFO_CNT_W'(operandPkg::FIFO_DEPTH));
	assign bufValid   = (count != '0);
	assign issueReady = !full || bufReady;	// A read frees the slot written this edge
	assign wrEn       = issueValid && issueReady;
	assign rdEn       = bufValid && bufReady;
	assign bufEntry   = mem[rdPtr];

	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end
		else
		begin
			if (wrEn)
				wrPtr <= wrPtr + 1'b1;	// Depth is a power of two, pointers wrap
			if (rdEn)
				rdPtr <= rdPtr + 1'b1;
			case ({wrEn, rdEn})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (wrEn)
			mem[wrPtr] <= issueEntry;
	end

endmodule

`default_nettype wire

// File: design/operandPath.sv
`default_nettype none

module operandPath (
	input  wire logic                 clk,
	input  wire logic                 arstN,
	input  wire logic                 inValid,
	output logic                      inReady,
	input  wire operandPkg::opRequestT inReq,
	output logic                      outValid,
	input  wire logic                 outReady,
	output operandPkg::opResultT      outResult
);

	logic                issueValid;
	logic                issueReady;
	operandPkg::opEntryT issueEntry;
	logic                bufValid;
	logic                bufReady;
	operandPkg::opEntryT bufEntry;

	instrIssue i_instrIssue (
		.clk        (clk),
		.arstN      (arstN),
		.inValid    (inValid),
		.inReady    (inReady),
		.inReq      (inReq),
		.issueValid (issueValid),
		.issueReady (issueReady),
		.issueEntry (issueEntry)
	);

	operandFifo i_operandFifo (
		.clk        (clk),
		.arstN      (arstN),
		.issueValid (issueValid),
		.issueReady (issueReady),
		.issueEntry (issueEntry),
		.bufValid   (bufValid),
		.bufReady   (bufReady),
		.bufEntry   (bufEntry)
	);

	operandUnit i_operandUnit (
		.clk       (clk),
		.arstN     (arstN),
		.bufValid  (bufValid),
		.bufReady  (bufReady),
		.bufEntry  (bufEntry),
		.outValid  (outValid),
		.outReady  (outReady),
		.outResult (outResult)
	);

endmodule

`default_nettype wire

// File: design/operandPkg.sv
`default_nettype none

package operandPkg;

	typedef enum logic [2:0] {
		rotImm,
		shiftImm,
		splitOffset,
		offset12,
		multiCount,
		branchOffset,
		passThrough
	} operandFormT;

	localparam int FIFO_DEPTH = 4;
	localparam int FIFO_PTR_W = 2;
	localparam int FIFO_CNT_W = FIFO_PTR_W + 1;	// Count reaches FIFO_DEPTH

	typedef struct packed {
		armIsaPkg::instrWordU instr;
		logic [31:0]          rmValue;
		logic                 carryIn;
	} opRequestT;

	typedef struct packed {
		operandFormT form;
		opRequestT   req;
	} opEntryT;

	typedef struct packed {
		logic [31:0] operand;
		logic        carryOut;
	} opResultT;

endpackage

`default_nettype wire

// File: design/operandUnit.sv
`default_nettype none

module operandUnit (
	input  wire logic                clk,
	input  wire logic                arstN,
	input  wire logic                bufValid,
	output logic                     bufReady,
	input  wire operandPkg::opEntryT bufEntry,
	output logic                     outValid,
	input  wire logic                outReady,
	output operandPkg::opResultT     outResult
);

	operandPkg::opResultT shifted;

	shifterOperand i_shifterOperand (
		.entry  (bufEntry),
		.result (shifted)
	);

	assign bufReady = !outValid || outReady;	// Full throughput slice

	always_ff @(posedge clk or negedge arstN)
	begin
		if (!arstN)
			outValid <= 1'b0;
		else if (bufReady)
			outValid <= bufValid;
	end

	always_ff @(posedge clk)
	begin
		if (bufValid && bufReady)
			outResult <= shifted;
	end

endmodule

`default_nettype wire

// File: design/shifterOperand.sv
`default_nettype none

module shifterOperand (
	input  wire operandPkg::opEntryT entry,
	output operandPkg::opResultT     result
);

	logic [11:0] op2;
	logic [3:0]  rotate;
	logic [7:0]  imm8;
	logic [4:0]  rotAmt;
	logic [63:0] immPair;
	logic [63:0] immShift;
	logic [4:0]  shAmt;
	logic [4:0]  lslIdx;
	logic [4:0]  outIdx;
	logic [63:0] rmPair;
	logic [63:0] rmShift;
	logic [31:0] rm;
	logic        cin;
	logic [4:0]  popCount;
	armIsaPkg::shiftTypeT shType;

	assign op2    = entry.req.instr.dp.operand2;
	assign rm     = entry.req.rmValue;
	assign cin    = entry.req.carryIn;
	assign rotate = op2[armIsaPkg::OP2_ROT_HI:armIsaPkg::OP2_ROT_LO];
	assign imm8   = op2[armIsaPkg::OP2_IMM8_HI:armIsaPkg::OP2_IMM8_LO];
	assign shAmt  = op2[armIsaPkg::OP2_SHAMT_HI:armIsaPkg::OP2_SHAMT_LO];
	assign shType = armIsaPkg::shiftTypeT'(op2[armIsaPkg::OP2_STYPE_HI:armIsaPkg::OP2_STYPE_LO]);

	// Rotate right as the low half of a doubled word shifted right
	assign rotAmt   = {rotate, 1'b0};
	assign immPair  = {24'd0, imm8, 24'd0, imm8};
	assign immShift = immPair >> rotAmt;
	assign rmPair   = {rm, rm};
	assign rmShift  = rmPair >> shAmt;

	assign lslIdx = 5'd0 - shAmt;	// 32 - amount, valid for amounts 1..31
	assign outIdx = shAmt - 5'd1;	// Last bit shifted out to the right

	always_comb
	begin
		popCount = '0;
		for (int i = 0; i < 16; i++)
			popCount = popCount + 5'(entry.req.instr.mm.regList[i]);
	end

	always_comb
	begin
		result.operand  = rm;
		result.carryOut = cin;
		case (entry.form)
			operandPkg::rotImm:
			begin
				result.operand  = immShift[31:0];
				result.carryOut = (rotate != 4'd0) ? immShift[31] : cin;
			end
			operandPkg::shiftImm:
			begin
				case (shType)
					armIsaPkg::lsl:
					begin
						if (shAmt != 5'd0)
						begin
							result.operand  = rm << shAmt;
							result.carryOut = rm[lslIdx];
						end
					end
					armIsaPkg::lsr:
					begin
						result.operand  = (shAmt == 5'd0) ? 32'd0 : rm >> shAmt;
						result.carryOut = (shAmt == 5'd0) ? rm[31] : rm[outIdx];
					end
					armIsaPkg::asr:
					begin
						result.operand  = (shAmt == 5'd0) ? {32{rm[31]}} : 32'($signed(rm) >>> shAmt);
						result.carryOut = (shAmt == 5'd0) ? rm[31] : rm[outIdx];
					end
					default:
					begin
						result.operand  = (shAmt == 5'd0) ? {cin, rm[31:1]} : rmShift[31:0];	// RRX at zero
						result.carryOut = (shAmt == 5'd0) ? rm[0] : rm[outIdx];
					end
				endcase
			end
			operandPkg::splitOffset:
				result.operand = {24'd0, rotate, op2[armIsaPkg::OP2_RM_HI:armIsaPkg::OP2_RM_LO]};
			operandPkg::offset12:
				result.operand = {20'd0, op2};
			operandPkg::multiCount:
				result.operand = {25'd0, popCount, 2'b00};	// Four bytes per listed register
			operandPkg::branchOffset:
				result.operand = {{6{entry.req.instr.raw[23]}}, entry.req.instr.raw[23:0], 2'b00};
			default:
			begin
				result.operand  = rm;
				result.carryOut = cin;
			end
		endcase
	end

endmodule

`default_nettype wire

// File: project.f
design/armIsaPkg.sv
design/operandPkg.sv
design/instrIssue.sv
design/operandFifo.sv
design/shifterOperand.sv
design/operandUnit.sv
design/operandPath.sv
bench/operandCheck_assert.sv
bench/operandPathTb.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f project.f --top-module operandPathTb &&
./obj_dir/VoperandPathTb +verilator+error+limit+1000 | tee /dev/stderr |
grep -q "All tests passed" ||
exit 1
